// ==== rtl/fixPkg.sv ====
package fixPkg;

    // Signed Q8.8 element format
    localparam int INT_BITS = 8;
    localparam int FRAC_BITS = 8;
    localparam int FIX_W = INT_BITS + FRAC_BITS;

    typedef logic signed [FIX_W-1:0] fixT;

    // Full precision product of two elements
    typedef logic signed [2*FIX_W-1:0] fixWideT;

    localparam fixT FIX_ZERO = '0;

endpackage

// ==== rtl/opPkg.sv ====
package opPkg;

    // Upper bound on lanes carried in a command
    localparam int MAX_LANES = 8;

    typedef enum logic [1:0] {
        OP_SUM  = 2'd0,
        OP_DOT  = 2'd1,
        OP_RSV2 = 2'd2,
        OP_RSV3 = 2'd3
    } opT;

    typedef fixPkg::fixT [MAX_LANES-1:0] vecT;

    // Lanes at or above LANES are ignored by the datapath
    typedef struct packed {
        opT  op;
        logic relu;
        vecT vecA;
        vecT vecB;
    } cmdT;

    typedef struct packed {
        logic isDot;
        logic relu;
        logic bad;
        vecT  vecA;
        vecT  vecB;
    } uopT;

    typedef struct packed {
        fixPkg::fixT value;
        logic        err;
    } resT;

endpackage

// ==== rtl/creditFifo.sv ====
`timescale 1ns/10ps

module creditFifo #(
    parameter type payloadT = logic,
    parameter int  DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  payloadT din,
    input  logic    pop,
    output payloadT dout,
    output logic    notEmpty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payloadT mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0] count;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head word is visible without a read cycle
    assign dout = mem[rdPtr];
    assign notEmpty = (count != '0);

endmodule

// ==== rtl/opDecode.sv ====
`timescale 1ns/10ps

module opDecode #(
    parameter int RES_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       headValid,
    input  opPkg::cmdT head,
    output logic       pop,
    output logic       cmdCredit,
    output logic       uopValid,
    output opPkg::uopT uop,
    input  logic       slotFree
);
    import opPkg::*;

    localparam int CNT_W = $clog2(RES_DEPTH + 1);

    // Results issued but not yet sent downstream
    logic [CNT_W-1:0] inFlight;
    logic issue;

    assign issue = headValid && (inFlight < CNT_W'(RES_DEPTH));
    assign pop = issue;
    assign cmdCredit = issue;
    assign uopValid = issue;

    always_comb begin
        uop.isDot = (head.op == OP_DOT);
        uop.relu = head.relu;
        uop.bad = !(head.op inside {OP_SUM, OP_DOT});
        uop.vecA = head.vecA;
        uop.vecB = head.vecB;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= '0;
        end else if (issue && !slotFree) begin
            inFlight <= inFlight + 1'b1;
        end else if (slotFree && !issue) begin
            inFlight <= inFlight - 1'b1;
        end
    end

endmodule

// ==== rtl/fixLane.sv ====
`timescale 1ns/10ps

module fixLane (
    input  logic        isDot,
    input  fixPkg::fixT a,
    input  fixPkg::fixT b,
    output fixPkg::fixT y
);
    import fixPkg::*;

    fixWideT prod;
    fixT     scaled;
    fixT     sumAB;

    assign prod = fixWideT'(a) * fixWideT'(b);

    // Arithmetic shift drops the extra fraction bits of the product
    assign scaled = fixT'(prod >>> FRAC_BITS);

    // Wraps at the element width
    assign sumAB = a + b;

    assign y = isDot ? scaled : sumAB;

endmodule

// ==== rtl/fixSum.sv ====
`timescale 1ns/10ps

module fixSum #(
    parameter int LANES = 4,
    parameter int ADDERS_COMB = 2
) (
    input  logic                    clk,
    input  fixPkg::fixT [LANES-1:0] terms,
    output fixPkg::fixT             sum
);
    import fixPkg::*;

    localparam int LAYERS = $clog2(LANES);

    // Number of partial sums entering layer n
    function automatic int countAt(int n);
        int c;
        c = LANES;
        for (int i = 0; i < n; i++) begin
            c = (c + 1) / 2;
        end
        return c;
    endfunction

    for (genvar i = 0; i < LAYERS; i++) begin : gLayer
        localparam int N_IN = countAt(i);
        localparam int N_OUT = countAt(i + 1);

        fixT layerIn [N_IN];
        fixT layerSum [N_OUT];
        fixT layerOut [N_OUT];

        for (genvar k = 0; k < N_IN; k++) begin : gIn
            if (i == 0) begin : gTerm
                assign layerIn[k] = terms[k];
            end else begin : gPrev
                assign layerIn[k] = gLayer[i-1].layerOut[k];
            end
        end

        for (genvar k = 0; k < N_OUT; k++) begin : gNode
            if (2 * k + 1 < N_IN) begin : gAdd
                assign layerSum[k] = layerIn[2*k] + layerIn[2*k+1];
            end else begin : gPass
                // Odd element rides through this layer
                assign layerSum[k] = layerIn[2*k];
            end
        end

        // Register after every ADDERS_COMB-th adder layer
        if ((i + 1) % ADDERS_COMB == 0) begin : gReg
            always_ff @(posedge clk) begin
                layerOut <= layerSum;
            end
        end else begin : gComb
            assign layerOut = layerSum;
        end
    end

    if (LAYERS == 0) begin : gSingle
        always_ff @(posedge clk) begin
            sum <= terms[0];
        end
    end else begin : gTree
        always_ff @(posedge clk) begin
            sum <= gLayer[LAYERS-1].layerOut[0];
        end
    end

endmodule

// ==== rtl/vecExecute.sv ====
`timescale 1ns/10ps

module vecExecute #(
    parameter int LANES = 4,
    parameter int ADDERS_COMB = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       uopValid,
    input  opPkg::uopT uop,
    output logic       outValid,
    output opPkg::resT outRes,
    output logic       outRelu
);
    import fixPkg::*;

    // Lane register, tree registers, then the tree output register
    localparam int TREE_LAT = $clog2(LANES) / ADDERS_COMB + 1;
    localparam int LAT = TREE_LAT + 1;

    typedef struct packed {
        logic valid;
        logic relu;
        logic bad;
    } tagT;

    fixT [LANES-1:0] laneY;
    fixT [LANES-1:0] laneQ;
    fixT treeSum;
    tagT tagIn;
    tagT tagPipe [LAT];

    for (genvar k = 0; k < LANES; k++) begin : gLane
        fixLane i_lane (
            .isDot (uop.isDot),
            .a     (uop.vecA[k]),
            .b     (uop.vecB[k]),
            .y     (laneY[k])
        );
    end

    always_ff @(posedge clk) begin
        laneQ <= laneY;
    end

    fixSum #(
        .LANES       (LANES),
        .ADDERS_COMB (ADDERS_COMB)
    ) i_tree (
        .clk   (clk),
        .terms (laneQ),
        .sum   (treeSum)
    );

    assign tagIn.valid = uopValid;
    assign tagIn.relu = uop.relu;
    assign tagIn.bad = uop.bad;

    // Tag follows its data through the lane and tree registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < LAT; k++) begin
                tagPipe[k] <= '0;
            end
        end else begin
            tagPipe[0] <= tagIn;
            for (int k = 1; k < LAT; k++) begin
                tagPipe[k] <= tagPipe[k-1];
            end
        end
    end

    assign outValid = tagPipe[LAT-1].valid;
    assign outRelu = tagPipe[LAT-1].relu;
    assign outRes.value = treeSum;
    assign outRes.err = tagPipe[LAT-1].bad;

endmodule

// ==== rtl/resultStage.sv ====
`timescale 1ns/10ps

module resultStage #(
    parameter int RES_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  opPkg::resT inRes,
    input  logic       relu,
    output logic       resValid,
    output opPkg::resT res,
    input  logic       resCredit,
    output logic       slotFree
);
    import fixPkg::*;
    import opPkg::*;

    localparam int CRED_W = $clog2(RES_CREDITS + 1);

    resT fixedRes;
    resT headRes;
    logic headValid;
    logic send;
    logic [CRED_W-1:0] outCredits;

    // Errors and negative ReLU results leave as zero
    always_comb begin
        fixedRes = inRes;
        if (inRes.err || (relu && inRes.value[FIX_W-1])) begin
            fixedRes.value = FIX_ZERO;
        end
    end

    creditFifo #(
        .payloadT (resT),
        .DEPTH    (RES_DEPTH)
    ) i_resFifo (
        .clk      (clk),
        .rst      (rst),
        .push     (inValid),
        .din      (fixedRes),
        .pop      (send),
        .dout     (headRes),
        .notEmpty (headValid)
    );

    assign send = headValid && (outCredits != '0);
    assign resValid = send;
    assign res = headRes;
    assign slotFree = send;

    always_ff @(posedge clk) begin
        if (rst) begin
            outCredits <= CRED_W'(RES_CREDITS);
        end else if (send && !resCredit) begin
            outCredits <= outCredits - 1'b1;
        end else if (resCredit && !send) begin
            outCredits <= outCredits + 1'b1;
        end
    end

endmodule

// ==== rtl/dotEngineTop.sv ====
`timescale 1ns/10ps

module dotEngineTop #(
    parameter int LANES = 4,
    parameter int ADDERS_COMB = 2,
    parameter int CMD_DEPTH = 4,
    parameter int RES_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmdValid,
    input  opPkg::cmdT cmd,
    output logic       cmdCredit,
    output logic       resValid,
    output opPkg::resT res,
    input  logic       resCredit
);
    import opPkg::*;

    cmdT  headCmd;
    logic headValid;
    logic popCmd;
    logic uopValid;
    uopT  uop;
    logic execValid;
    resT  execRes;
    logic execRelu;
    logic slotFree;

    if (LANES > MAX_LANES) begin : gLanesCheck
        $error("LANES exceeds the vector field width");
    end

    creditFifo #(
        .payloadT (cmdT),
        .DEPTH    (CMD_DEPTH)
    ) i_cmdFifo (
        .clk      (clk),
        .rst      (rst),
        .push     (cmdValid),
        .din      (cmd),
        .pop      (popCmd),
        .dout     (headCmd),
        .notEmpty (headValid)
    );

    opDecode #(
        .RES_DEPTH (RES_DEPTH)
    ) i_decode (
        .clk       (clk),
        .rst       (rst),
        .headValid (headValid),
        .head      (headCmd),
        .pop       (popCmd),
        .cmdCredit (cmdCredit),
        .uopValid  (uopValid),
        .uop       (uop),
        .slotFree  (slotFree)
    );

    vecExecute #(
        .LANES       (LANES),
        .ADDERS_COMB (ADDERS_COMB)
    ) i_exec (
        .clk      (clk),
        .rst      (rst),
        .uopValid (uopValid),
        .uop      (uop),
        .outValid (execValid),
        .outRes   (execRes),
        .outRelu  (execRelu)
    );

    resultStage #(
        .RES_DEPTH   (RES_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) i_result (
        .clk       (clk),
        .rst       (rst),
        .inValid   (execValid),
        .inRes     (execRes),
        .relu      (execRelu),
        .resValid  (resValid),
        .res       (res),
        .resCredit (resCredit),
        .slotFree  (slotFree)
    );

endmodule

// ==== verif/dotEngine_assertions.sv ====
`timescale 1ns/10ps

module dotEngine_assertions #(
    parameter int CMD_DEPTH = 4,
    parameter int RES_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic cmdValid,
    input logic resValid,
    input logic resCredit,
    input logic [((CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1):0] cmdCount,
    input logic [$clog2(RES_DEPTH + 1)-1:0] inFlight
);

    localparam int CMD_CNT_W = ((CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1) + 1;
    localparam int FLIGHT_W = $clog2(RES_DEPTH + 1);

    // Output credits held by the DUT, rebuilt from the result port traffic
    int creditModel;

    always_ff @(posedge clk) begin
        if (rst) begin
            creditModel <= RES_CREDITS;
        end else begin
            creditModel <= creditModel + int'(resCredit) - int'(resValid);
        end
    end

    // A send always consumes an output credit the DUT already holds
    creditHeld: assert property (@(posedge clk) disable iff (rst)
        resValid |-> (creditModel > 0))
        else $error("resValid raised with an empty output credit counter");

    inFlightBound: assert property (@(posedge clk) disable iff (rst)
        inFlight <= FLIGHT_W'(RES_DEPTH))
        else $error("Decode in-flight count above the result queue depth");

    // Sender credits keep the command queue from overflowing
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        cmdValid |-> (cmdCount < CMD_CNT_W'(CMD_DEPTH)))
        else $error("Command pushed into a full command queue");

endmodule

bind dotEngineTop dotEngine_assertions #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RES_DEPTH   (RES_DEPTH),
    .RES_CREDITS (RES_CREDITS)
) i_assertions (
    .clk        (clk),
    .rst        (rst),
    .cmdValid   (cmdValid),
    .resValid   (resValid),
    .resCredit  (resCredit),
    .cmdCount   (i_cmdFifo.count),
    .inFlight   (i_decode.inFlight)
);

// ==== verif/dotEngineTb.sv ====
`timescale 1ns/10ps

module dotEngineTb;
    import fixPkg::*;
    import opPkg::*;

    localparam int LANES = 4;
    localparam int ADDERS_COMB = 2;
    localparam int CMD_DEPTH = 4;
    localparam int RES_DEPTH = 4;
    localparam int RES_CREDITS = 2;
    localparam int NUM_CMDS = 300;
    localparam int MAX_CYCLES = NUM_CMDS * 20;

    logic clk = 1'b0;
    logic rst;
    logic cmdValid;
    cmdT  cmd;
    logic cmdCredit;
    logic resValid;
    resT  res;
    logic resCredit;

    resT expQ [$];
    int sendCredits = CMD_DEPTH;
    int dutCredits = RES_CREDITS;
    int owedCredits = 0;
    int creditGap = 0;
    int sent = 0;
    int received = 0;
    int creditPulses = 0;
    int cycles = 0;
    int mismatches = 0;
    int failures = 0;

    dotEngineTop #(
        .LANES       (LANES),
        .ADDERS_COMB (ADDERS_COMB),
        .CMD_DEPTH   (CMD_DEPTH),
        .RES_DEPTH   (RES_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdCredit (cmdCredit),
        .resValid  (resValid),
        .res       (res),
        .resCredit (resCredit)
    );

    always #10 clk = ~clk;

    // Expected result from the opcode rules, lanes past LANES ignored
    function automatic resT refResult(cmdT c);
        resT r;
        longint prod;
        fixT acc;
        acc = '0;
        r.err = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (c.op == OP_DOT) begin
                prod = longint'(c.vecA[i]) * longint'(c.vecB[i]);
                acc = acc + fixT'(prod >>> FRAC_BITS);
            end else begin
                acc = acc + c.vecA[i] + c.vecB[i];
            end
        end
        if (c.op != OP_DOT && c.op != OP_SUM) begin
            acc = '0;
            r.err = 1'b1;
        end
        if (c.relu && acc[FIX_W-1]) begin
            acc = '0;
        end
        r.value = acc;
        return r;
    endfunction

    // Full range now and then, otherwise values near zero
    function automatic fixT randElem();
        if ($urandom_range(3, 0) == 0) begin
            return fixT'($urandom);
        end
        return fixT'(int'($urandom_range(1023, 0)) - 512);
    endfunction

    function automatic cmdT randCmd();
        cmdT c;
        int pick;
        pick = int'($urandom_range(7, 0));
        case (pick)
            0, 1, 2: c.op = OP_SUM;
            3, 4, 5: c.op = OP_DOT;
            6: c.op = OP_RSV2;
            default: c.op = OP_RSV3;
        endcase
        c.relu = ($urandom_range(1, 0) == 1);
        for (int i = 0; i < MAX_LANES; i++) begin
            c.vecA[i] = randElem();
            c.vecB[i] = randElem();
        end
        return c;
    endfunction

    // Mostly short gaps, with an occasional long stall on the result side
    function automatic int pickGap();
        if ($urandom_range(11, 0) == 0) begin
            return 40;
        end
        return int'($urandom_range(6, 0));
    endfunction

    task automatic driveCommand();
        cmdT c;
        cmdValid = 1'b0;
        if (sent < NUM_CMDS && sendCredits > 0 && $urandom_range(3, 0) != 0) begin
            c = randCmd();
            cmd = c;
            cmdValid = 1'b1;
            expQ.push_back(refResult(c));
            sendCredits--;
            sent++;
        end
    endtask

    task automatic driveCredit();
        resCredit = 1'b0;
        if (creditGap > 0) begin
            creditGap--;
        end else if (owedCredits > 0) begin
            resCredit = 1'b1;
            owedCredits--;
            creditGap = pickGap();
        end
    endtask

    task automatic checkResult();
        resT exp;
        assert (dutCredits > 0) else begin
            failures++;
            $display("Result sent while the DUT held no output credit");
        end
        dutCredits--;
        owedCredits++;
        received++;
        assert (expQ.size() > 0) else begin
            failures++;
            $display("Result %0d arrived with no command outstanding", received);
        end
        if (expQ.size() > 0) begin
            exp = expQ.pop_front();
            assert (res.value == exp.value) else begin
                mismatches++;
                $display("MISMATCH res.value: got %h expected %h at result %0d",
                         res.value, exp.value, received);
            end
            assert (res.err == exp.err) else begin
                mismatches++;
                $display("MISMATCH res.err: got %h expected %h at result %0d",
                         res.err, exp.err, received);
            end
        end
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (cmdCredit) begin
                sendCredits++;
                creditPulses++;
            end
            if (resValid) begin
                checkResult();
            end
            if (resCredit) begin
                dutCredits++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d results received",
                     cycles, received, NUM_CMDS);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h80b9));
        rst = 1'b1;
        cmdValid = 1'b0;
        cmd = '0;
        resCredit = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!(sent == NUM_CMDS && received == NUM_CMDS)) begin
            @(posedge clk);
            #1;
            driveCommand();
            driveCredit();
        end
        // Drain window catches duplicated results
        repeat (20) begin
            @(posedge clk);
            #1;
            driveCredit();
        end
        assert (creditPulses == NUM_CMDS) else begin
            failures++;
            $display("cmdCredit pulsed %0d times for %0d commands", creditPulses, NUM_CMDS);
        end
        assert (received == NUM_CMDS && expQ.size() == 0) else begin
            failures++;
            $display("Received %0d results for %0d commands", received, NUM_CMDS);
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d results checked",
                 mismatches, failures, received);
        if (mismatches + failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/fixPkg.sv
rtl/opPkg.sv
rtl/creditFifo.sv
rtl/opDecode.sv
rtl/fixLane.sv
rtl/fixSum.sv
rtl/vecExecute.sv
rtl/resultStage.sv
rtl/dotEngineTop.sv
verif/dotEngine_assertions.sv
verif/dotEngineTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module dotEngineTb -f filelist.f -o dotEngineSim

# A failed assertion may stop the simulator, so its status is not used directly
simOut=$(./obj_dir/dotEngineSim 2>&1) || true
echo "$simOut"

if grep -qx "Simulation finished: PASS" <<< "$simOut"; then
    exit 0
fi
exit 1
